// File: sources.f
+incdir+include
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/alu_stage.sv
src/mul_stage.sv
src/reorder_buffer.sv
src/core_top.sv
verif/core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module core_tb -o core_sim

out=$(./obj_dir/core_sim)
echo "$out"

# Pass only if the testbench printed its pass line
echo "$out" | grep -q "^Test completed successfully$"

// File: verif/core_tb.sv
`include "core_defines.svh"

module core_tb
    import core_pkg::*;
();

localparam logic [`PC_WIDTH-1:0] BOOT = 16'h0040;
// Sum of all program lengths below
localparam int TOTAL_INSTR     = 80;
localparam int WATCHDOG_CYCLES = TOTAL_INSTR * (`MUL_LATENCY + 6) + 100;

logic                           clock;
logic                           arst_n;
logic [`PC_WIDTH-1:0]           boot_addr;
logic [`PC_WIDTH-1:0]           imem_addr;
logic [`INSTR_WIDTH-1:0]        imem_data;
logic                           commit_valid;
logic [`REG_ADDR_WIDTH-1:0]     commit_dest;
logic [`DATA_WIDTH-1:0]         commit_data;
logic [`PC_WIDTH-1:0]           commit_pc;

// Instruction memory over the whole address space
logic [`INSTR_WIDTH-1:0]        imem [0:65535];

// Expected commit list from the reference model
logic [`REG_ADDR_WIDTH-1:0]     exp_dest [256];
logic [`DATA_WIDTH-1:0]         exp_data [256];
logic [`PC_WIDTH-1:0]           exp_pc   [256];
logic [`DATA_WIDTH-1:0]         model_regs [`REG_COUNT];
int                             exp_count;
logic [7:0]                     commit_idx;
logic [`REG_ADDR_WIDTH-1:0]     exp_dest_now;
logic [`DATA_WIDTH-1:0]         exp_data_now;
logic [`PC_WIDTH-1:0]           exp_pc_now;

int                             errors;
int                             tests_failed;
int                             test_num;
string                          test_name;
int                             prog_len;

core_top uut (
    .clock          ( clock         ),
    .arst_n         ( arst_n        ),
    .boot_addr      ( boot_addr     ),
    .imem_addr      ( imem_addr     ),
    .imem_data      ( imem_data     ),
    .commit_valid   ( commit_valid  ),
    .commit_dest    ( commit_dest   ),
    .commit_data    ( commit_data   ),
    .commit_pc      ( commit_pc     )
);

always #10 clock = ~clock;

// Combinational instruction read
assign imem_data = imem[imem_addr];

//////////////////////////////////////////////////
// Commit tracking and checks

always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        commit_idx <= '0;
    end else if (commit_valid) begin
        commit_idx <= commit_idx + 8'd1;
    end
end

assign exp_dest_now = exp_dest[commit_idx];
assign exp_data_now = exp_data[commit_idx];
assign exp_pc_now   = exp_pc[commit_idx];

// Reset and the cycle after it
assert property (@(posedge clock) !arst_n |=> (imem_addr == boot_addr))
    else begin
        errors++;
        $display("[FAIL] imem_addr got %h expected %h", $sampled(imem_addr), $sampled(boot_addr));
    end
assert property (@(posedge clock) !arst_n |=> !commit_valid)
    else begin
        errors++;
        $display("[FAIL] commit_valid got %h expected 0", $sampled(commit_valid));
    end

// Each commit against the next model entry
assert property (@(posedge clock) disable iff (!arst_n)
    commit_valid |-> (int'(commit_idx) < exp_count))
    else begin
        errors++;
        $display("Unexpected commit to r%0d from pc %h after all %0d expected commits",
                 $sampled(commit_dest), $sampled(commit_pc), exp_count);
    end
assert property (@(posedge clock) disable iff (!arst_n)
    commit_valid |-> (commit_dest == exp_dest_now))
    else begin
        errors++;
        $display("[FAIL] commit_dest got %h expected %h", $sampled(commit_dest),
                 $sampled(exp_dest_now));
    end
assert property (@(posedge clock) disable iff (!arst_n)
    commit_valid |-> (commit_data == exp_data_now))
    else begin
        errors++;
        $display("[FAIL] commit_data got %h expected %h", $sampled(commit_data),
                 $sampled(exp_data_now));
    end
assert property (@(posedge clock) disable iff (!arst_n)
    commit_valid |-> (commit_pc == exp_pc_now))
    else begin
        errors++;
        $display("[FAIL] commit_pc got %h expected %h", $sampled(commit_pc),
                 $sampled(exp_pc_now));
    end

//////////////////////////////////////////////////
// Program building

function automatic logic [31:0] encode(opcode_t op, int rd, int rs1, int rs2,
                                       logic [15:0] imm);
    logic [31:0] w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB]          = op;
    w[`RD_LSB  +: `REG_ADDR_WIDTH]      = rd[2:0];
    w[`RS1_LSB +: `REG_ADDR_WIDTH]      = rs1[2:0];
    w[`RS2_LSB +: `REG_ADDR_WIDTH]      = rs2[2:0];
    w[`IMM_WIDTH-1:0]                   = imm;
    return w;
endfunction

function automatic opcode_t pick_alu_op();
    case ($urandom_range(5, 0))
        0:       return OP_ADD;
        1:       return OP_SUB;
        2:       return OP_AND;
        3:       return OP_OR;
        4:       return OP_XOR;
        default: return OP_ADDI;
    endcase
endfunction

task automatic emit(input logic [31:0] w);
    imem[BOOT + prog_len[15:0]] = w;
    prog_len++;
endtask

// r1 to r4 loaded with random values
task automatic seed_regs();
    for (int r = 1; r <= 4; r++) begin
        emit(encode(OP_ADDI, r, 0, 0, 16'($urandom)));
    end
endtask

// Self loop where the core parks
task automatic emit_end();
    emit(encode(OP_BEQ, 0, 0, 0, 16'h0000));
endtask

//////////////////////////////////////////////////
// Reference model executing in order from BOOT

task automatic run_model();
    logic [15:0]    pc;
    logic [31:0]    w;
    logic [31:0]    a;
    logic [31:0]    b;
    logic [31:0]    imm;
    logic [31:0]    res;
    opcode_t        op;
    for (int r = 0; r < `REG_COUNT; r++) begin
        model_regs[r] = '0;
    end
    exp_count = 0;
    pc = BOOT;
    for (int steps = 0; steps < 200; steps++) begin
        w   = imem[pc];
        op  = opcode_t'(w[`OPCODE_MSB:`OPCODE_LSB]);
        a   = model_regs[w[`RS1_LSB +: `REG_ADDR_WIDTH]];
        b   = model_regs[w[`RS2_LSB +: `REG_ADDR_WIDTH]];
        imm = {{16{w[15]}}, w[15:0]};
        if (op == OP_BEQ) begin
            // Taken branch to itself ends the program
            if (a == b && imm == '0) begin
                break;
            end
            pc = (a == b) ? pc + imm[15:0] : pc + 16'd1;
        end else begin
            case (op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_ADDI: res = a + imm;
                OP_MUL:  res = a * b;
                default: res = '0;
            endcase
            if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_MUL}) begin
                model_regs[w[`RD_LSB +: `REG_ADDR_WIDTH]] = res;
                exp_dest[exp_count] = w[`RD_LSB +: `REG_ADDR_WIDTH];
                exp_data[exp_count] = res;
                exp_pc[exp_count]   = pc;
                exp_count++;
            end
            pc = pc + 16'd1;
        end
    end
endtask

//////////////////////////////////////////////////
// Test sequencing

// Core held in reset while the program is rewritten
task automatic start_test(input int num, input string name);
    @(posedge clock);
    arst_n <= 1'b0;
    @(posedge clock);
    test_num  = num;
    test_name = name;
    prog_len  = 0;
endtask

task automatic finish_test();
    int errors_before;
    errors_before = errors;
    run_model();
    repeat (9) @(posedge clock);
    arst_n <= 1'b1;
    while (int'(commit_idx) < exp_count) begin
        @(posedge clock);
    end
    // Room for stray commits
    repeat (8) @(posedge clock);
    if (errors != errors_before) begin
        tests_failed++;
    end
    $display("test %0d %s: %0d commits, %s", test_num, test_name, exp_count,
             (errors == errors_before) ? "ok" : "errors");
endtask

initial begin
    void'($urandom(32'h7473));
    clock        = 1'b0;
    arst_n       = 1'b0;
    boot_addr    = BOOT;
    errors       = 0;
    tests_failed = 0;
    exp_count    = 0;
    test_num     = 0;
    test_name    = "init";
    // NOP fill with the address in the low bits
    for (int a = 0; a < 65536; a++) begin
        imem[a] = {16'h0000, a[15:0]};
    end

    start_test(1, "reset");
    for (int i = 0; i < 3; i++) begin
        emit(encode(OP_NOP, 0, 0, 0, 16'($urandom)));
    end
    emit_end();
    finish_test();

    // Sources r1..r4 and results r5..r7
    start_test(2, "independent_alu");
    seed_regs();
    for (int i = 0; i < 12; i++) begin
        emit(encode(pick_alu_op(), 5 + i % 3, $urandom_range(4, 1), $urandom_range(4, 1),
                    16'($urandom)));
    end
    emit_end();
    finish_test();

    // ALU results complete ahead of the MUL
    start_test(3, "mul_then_alu");
    seed_regs();
    emit(encode(OP_MUL, 5, $urandom_range(4, 1), $urandom_range(4, 1), 16'h0000));
    for (int i = 0; i < 6; i++) begin
        emit(encode(pick_alu_op(), 6 + i % 2, $urandom_range(4, 1), $urandom_range(4, 1),
                    16'($urandom)));
    end
    emit_end();
    finish_test();

    start_test(4, "dependency_chains");
    seed_regs();
    for (int i = 0; i < 16; i++) begin
        emit(encode(($urandom_range(2, 0) == 0) ? OP_MUL : pick_alu_op(),
                    $urandom_range(7, 1), $urandom_range(7, 1), $urandom_range(7, 1),
                    16'($urandom)));
    end
    emit_end();
    finish_test();

    // r2 = r1 + 1 so the second BEQ never takes
    start_test(5, "branches");
    emit(encode(OP_ADDI, 1, 0, 0, 16'($urandom)));
    emit(encode(OP_ADDI, 2, 1, 0, 16'h0001));
    emit(encode(OP_ADDI, 3, 0, 0, 16'($urandom)));
    emit(encode(OP_ADDI, 4, 0, 0, 16'($urandom)));
    emit(encode(OP_BEQ, 0, 1, 1, 16'h0004));
    for (int i = 0; i < 3; i++) begin
        emit(encode(OP_ADDI, 5 + i, 3, 0, 16'($urandom)));
    end
    emit(encode(OP_ADD, 5, 3, 4, 16'h0000));
    emit(encode(OP_BEQ, 0, 1, 2, 16'h0002));
    emit(encode(OP_ADD, 6, 1, 3, 16'h0000));
    emit(encode(OP_XOR, 7, 2, 4, 16'h0000));
    emit_end();
    finish_test();

    // More MULs than ROB slots
    start_test(6, "rob_full_mul");
    seed_regs();
    for (int i = 0; i < 8; i++) begin
        emit(encode(OP_MUL, 5 + i % 3, $urandom_range(4, 1), $urandom_range(4, 1), 16'h0000));
    end
    emit_end();
    finish_test();

    $display("tests run 6, tests failed %0d, check errors %0d", tests_failed, errors);
    if (errors == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

// Watchdog over the whole run
initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout in test %0d %s after %0d cycles, commits stopped at %0d of %0d",
             test_num, test_name, WATCHDOG_CYCLES, commit_idx, exp_count);
    $display("Test failed");
    $finish;
end

endmodule

// File: src/core_top.sv
`include "core_defines.svh"

module core_top
    import core_pkg::*;
(
    input   logic                           clock,
    input   logic                           arst_n,
    input   logic   [`PC_WIDTH-1:0]         boot_addr,

    // Instruction memory
    output  logic   [`PC_WIDTH-1:0]         imem_addr,
    input   logic   [`INSTR_WIDTH-1:0]      imem_data,

    // Committed register writes
    output  logic                           commit_valid,
    output  logic   [`REG_ADDR_WIDTH-1:0]   commit_dest,
    output  logic   [`DATA_WIDTH-1:0]       commit_data,
    output  logic   [`PC_WIDTH-1:0]         commit_pc
);

//////////////////////////////////////////////////
// Stage to stage signals

// Fetch to decode
logic                       fetch_valid;
logic [`INSTR_WIDTH-1:0]    fetch_instr;
logic [`PC_WIDTH-1:0]       fetch_pc;
logic                       decode_stall;

// Decode to execution units
logic                       alu_issue;
alu_op_t                    alu_req;
logic                       mul_issue;
mul_op_t                    mul_req;
logic                       rob_alloc;

// Execution units to reorder buffer
logic                       alu_done;
completion_t                alu_result;
logic                       mul_done;
completion_t                mul_result;

// Branch redirect, flushes fetch and decode
logic                       take_branch;
logic [`PC_WIDTH-1:0]       branch_pc;

// Reorder buffer to decode
logic                       rob_full;
logic [`ROB_ID_WIDTH-1:0]   rob_tail;
logic [`ROB_ID_WIDTH-1:0]   commit_tag;

//////////////////////////////////////////////////
// Stages

fetch_stage
fetch_stage
(
    .clock          ( clock         ),
    .arst_n         ( arst_n        ),
    .boot_addr      ( boot_addr     ),
    .stall          ( decode_stall  ),
    .take_branch    ( take_branch   ),
    .branch_pc      ( branch_pc     ),
    .imem_data      ( imem_data     ),
    .imem_addr      ( imem_addr     ),
    .fetch_valid    ( fetch_valid   ),
    .fetch_instr    ( fetch_instr   ),
    .fetch_pc       ( fetch_pc      )
);

decode_stage
decode_stage
(
    .clock          ( clock         ),
    .arst_n         ( arst_n        ),
    .fetch_valid    ( fetch_valid   ),
    .fetch_instr    ( fetch_instr   ),
    .fetch_pc       ( fetch_pc      ),
    .take_branch    ( take_branch   ),
    .rob_full       ( rob_full      ),
    .rob_tail       ( rob_tail      ),
    // Register file written from the commit port
    .commit_valid   ( commit_valid  ),
    .commit_dest    ( commit_dest   ),
    .commit_data    ( commit_data   ),
    .commit_tag     ( commit_tag    ),
    .decode_stall   ( decode_stall  ),
    .alu_issue      ( alu_issue     ),
    .alu_req        ( alu_req       ),
    .mul_issue      ( mul_issue     ),
    .mul_req        ( mul_req       ),
    .rob_alloc      ( rob_alloc     )
);

alu_stage
alu_stage
(
    .clock          ( clock         ),
    .arst_n         ( arst_n        ),
    .alu_issue      ( alu_issue     ),
    .alu_req        ( alu_req       ),
    .alu_done       ( alu_done      ),
    .alu_result     ( alu_result    ),
    .take_branch    ( take_branch   ),
    .branch_pc      ( branch_pc     )
);

mul_stage
mul_stage
(
    .clock          ( clock         ),
    .arst_n         ( arst_n        ),
    .mul_issue      ( mul_issue     ),
    .mul_req        ( mul_req       ),
    .mul_done       ( mul_done      ),
    .mul_result     ( mul_result    )
);

reorder_buffer
reorder_buffer
(
    .clock          ( clock         ),
    .arst_n         ( arst_n        ),
    .rob_alloc      ( rob_alloc     ),
    .alu_done       ( alu_done      ),
    .alu_result     ( alu_result    ),
    .mul_done       ( mul_done      ),
    .mul_result     ( mul_result    ),
    .rob_full       ( rob_full      ),
    .rob_tail       ( rob_tail      ),
    .commit_valid   ( commit_valid  ),
    .commit_dest    ( commit_dest   ),
    .commit_data    ( commit_data   ),
    .commit_pc      ( commit_pc     ),
    .commit_tag     ( commit_tag    )
);

endmodule

// File: src/reorder_buffer.sv
`include "core_defines.svh"

module reorder_buffer
    import core_pkg::*;
(
    input   logic                           clock,
    input   logic                           arst_n,

    // Slot allocation from decode, at the tail
    input   logic                           rob_alloc,

    // Completions, out of order
    input   logic                           alu_done,
    input   completion_t                    alu_result,
    input   logic                           mul_done,
    input   completion_t                    mul_result,

    // State to decode
    output  logic                           rob_full,
    output  logic   [`ROB_ID_WIDTH-1:0]     rob_tail,

    // In-order commit
    output  logic                           commit_valid,
    output  logic   [`REG_ADDR_WIDTH-1:0]   commit_dest,
    output  logic   [`DATA_WIDTH-1:0]       commit_data,
    output  logic   [`PC_WIDTH-1:0]         commit_pc,
    output  logic   [`ROB_ID_WIDTH-1:0]     commit_tag
);

completion_t                slot_q  [`ROB_ENTRIES];
logic [`ROB_ENTRIES-1:0]    busy_q;
logic [`ROB_ENTRIES-1:0]    done_q;
// Pointers wrap naturally
logic [`ROB_ID_WIDTH-1:0]   head_q;
logic [`ROB_ID_WIDTH-1:0]   tail_q;
logic [`ROB_ID_WIDTH:0]     count_q;
logic                       retire;

// Oldest slot finished
assign retire   = busy_q[head_q] && done_q[head_q];
assign rob_full = (count_q == (`ROB_ID_WIDTH+1)'(`ROB_ENTRIES));
assign rob_tail = tail_q;

//////////////////////////////////////////////////
// Slot state and pointers

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        busy_q       <= '0;
        done_q       <= '0;
        head_q       <= '0;
        tail_q       <= '0;
        count_q      <= '0;
        commit_valid <= 1'b0;
    end else begin
        commit_valid <= retire;
        if (rob_alloc) begin
            busy_q[tail_q] <= 1'b1;
            done_q[tail_q] <= 1'b0;
            tail_q         <= tail_q + `ROB_ID_WIDTH'(1);
        end
        // Both units may finish in one cycle
        if (alu_done) begin
            done_q[alu_result.rob_id] <= 1'b1;
        end
        if (mul_done) begin
            done_q[mul_result.rob_id] <= 1'b1;
        end
        if (retire) begin
            busy_q[head_q] <= 1'b0;
            done_q[head_q] <= 1'b0;
            head_q         <= head_q + `ROB_ID_WIDTH'(1);
        end
        count_q <= count_q + (`ROB_ID_WIDTH+1)'(rob_alloc) - (`ROB_ID_WIDTH+1)'(retire);
    end
end

// Results and commit port
always_ff @(posedge clock) begin
    if (alu_done) begin
        slot_q[alu_result.rob_id] <= alu_result;
    end
    if (mul_done) begin
        slot_q[mul_result.rob_id] <= mul_result;
    end
    if (retire) begin
        commit_dest <= slot_q[head_q].dest;
        commit_data <= slot_q[head_q].data;
        commit_pc   <= slot_q[head_q].pc;
        commit_tag  <= slot_q[head_q].rob_id;
    end
end

// Completions land only in live, unfinished slots
assert property (@(posedge clock) disable iff (!arst_n)
    alu_done |-> (busy_q[alu_result.rob_id] && !done_q[alu_result.rob_id]));
assert property (@(posedge clock) disable iff (!arst_n)
    mul_done |-> (busy_q[mul_result.rob_id] && !done_q[mul_result.rob_id]));

endmodule

// File: src/mul_stage.sv
`include "core_defines.svh"

module mul_stage
    import core_pkg::*;
(
    input   logic           clock,
    input   logic           arst_n,

    // At most one request from decode per cycle
    input   logic           mul_issue,
    input   mul_op_t        mul_req,

    // Result to the reorder buffer
    output  logic           mul_done,
    output  completion_t    mul_result
);

localparam int HALF = `DATA_WIDTH / 2;

// Valid bit per stage
logic [`MUL_LATENCY-1:0]    valid_q;
// First stage holds partial products and tags
logic [`DATA_WIDTH-1:0]     part_lo_q;
logic [`DATA_WIDTH-1:0]     part_hi_q;
logic [`REG_ADDR_WIDTH-1:0] dest_q;
logic [`ROB_ID_WIDTH-1:0]   rob_id_q;
logic [`PC_WIDTH-1:0]       pc_q;
// Later stages carry the finished product
completion_t                pipe_q [1:`MUL_LATENCY-1];

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        valid_q <= '0;
    end else begin
        valid_q <= {valid_q[`MUL_LATENCY-2:0], mul_issue};
    end
end

//////////////////////////////////////////////////
// Datapath

always_ff @(posedge clock) begin
    // Multiplier split in two halves
    part_lo_q <= mul_req.src1 * mul_req.src2[HALF-1:0];
    part_hi_q <= mul_req.src1 * mul_req.src2[`DATA_WIDTH-1:HALF];
    dest_q    <= mul_req.dest;
    rob_id_q  <= mul_req.rob_id;
    pc_q      <= mul_req.pc;

    // Sum of halves keeps the low word only
    pipe_q[1].rob_id <= rob_id_q;
    pipe_q[1].dest   <= dest_q;
    pipe_q[1].data   <= part_lo_q + (part_hi_q << HALF);
    pipe_q[1].pc     <= pc_q;

    // Delay stages up to the fixed latency
    for (int i = 2; i < `MUL_LATENCY; i++) begin
        pipe_q[i] <= pipe_q[i-1];
    end
end

assign mul_done   = valid_q[`MUL_LATENCY-1];
assign mul_result = pipe_q[`MUL_LATENCY-1];

// Result arrives after the fixed latency with the issued tag and product
assert property (@(posedge clock) disable iff (!arst_n)
    mul_issue |-> ##(`MUL_LATENCY) (mul_done
        && (mul_result.rob_id == $past(mul_req.rob_id, `MUL_LATENCY))
        && (mul_result.data == $past(mul_req.src1 * mul_req.src2, `MUL_LATENCY))));

endmodule

// File: src/alu_stage.sv
`include "core_defines.svh"

module alu_stage
    import core_pkg::*;
(
    input   logic                       clock,
    input   logic                       arst_n,

    // Request from decode
    input   logic                       alu_issue,
    input   alu_op_t                    alu_req,

    // Result to the reorder buffer
    output  logic                       alu_done,
    output  completion_t                alu_result,

    // Redirect to fetch and decode
    output  logic                       take_branch,
    output  logic   [`PC_WIDTH-1:0]     branch_pc
);

logic [`DATA_WIDTH-1:0] result;
logic                   writes_rd;
logic                   operands_equal;

// Integer operations
always_comb begin
    case (alu_req.op)
        OP_ADD:  result = alu_req.src1 + alu_req.src2;
        OP_SUB:  result = alu_req.src1 - alu_req.src2;
        OP_AND:  result = alu_req.src1 & alu_req.src2;
        OP_OR:   result = alu_req.src1 | alu_req.src2;
        OP_XOR:  result = alu_req.src1 ^ alu_req.src2;
        OP_ADDI: result = alu_req.src1 + alu_req.imm;
        default: result = '0;
    endcase
end

// BEQ, NOP and unknown codes produce no result
assign writes_rd      = alu_req.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};
assign operands_equal = (alu_req.src1 == alu_req.src2);

//////////////////////////////////////////////////
// Strobes, one cycle after issue

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        alu_done    <= 1'b0;
        take_branch <= 1'b0;
    end else begin
        alu_done    <= alu_issue && writes_rd;
        take_branch <= alu_issue && (alu_req.op == OP_BEQ) && operands_equal;
    end
end

// Result and branch target
// Target is pc relative, in instructions
always_ff @(posedge clock) begin
    if (alu_issue) begin
        alu_result.rob_id <= alu_req.rob_id;
        alu_result.dest   <= alu_req.dest;
        alu_result.data   <= result;
        alu_result.pc     <= alu_req.pc;
        branch_pc         <= alu_req.pc + alu_req.imm[`PC_WIDTH-1:0];
    end
end

endmodule

// File: src/decode_stage.sv
`include "core_defines.svh"

module decode_stage
    import core_pkg::*;
(
    input   logic                           clock,
    input   logic                           arst_n,

    // From fetch
    input   logic                           fetch_valid,
    input   logic   [`INSTR_WIDTH-1:0]      fetch_instr,
    input   logic   [`PC_WIDTH-1:0]         fetch_pc,

    // Flush from the ALU
    input   logic                           take_branch,

    // Reorder buffer state
    input   logic                           rob_full,
    input   logic   [`ROB_ID_WIDTH-1:0]     rob_tail,

    // Commit port, writes the register file
    input   logic                           commit_valid,
    input   logic   [`REG_ADDR_WIDTH-1:0]   commit_dest,
    input   logic   [`DATA_WIDTH-1:0]       commit_data,
    input   logic   [`ROB_ID_WIDTH-1:0]     commit_tag,

    // Stall level back to fetch
    output  logic                           decode_stall,

    // Issue
    output  logic                           alu_issue,
    output  alu_op_t                        alu_req,
    output  logic                           mul_issue,
    output  mul_op_t                        mul_req,
    output  logic                           rob_alloc
);

// Architectural registers
logic [`DATA_WIDTH-1:0]     regs_q      [`REG_COUNT];
// Scoreboard, pending bit and owning ROB slot per register
logic [`REG_COUNT-1:0]      pending_q;
logic [`ROB_ID_WIDTH-1:0]   owner_q     [`REG_COUNT];

opcode_t                    op;
logic [`REG_ADDR_WIDTH-1:0] rd;
logic [`REG_ADDR_WIDTH-1:0] rs1;
logic [`REG_ADDR_WIDTH-1:0] rs2;
logic [`DATA_WIDTH-1:0]     imm;
logic                       uses_rs1;
logic                       uses_rs2;
logic                       writes_rd;
logic                       is_mul;
logic                       src_busy;
logic                       can_issue;

//////////////////////////////////////////////////
// Field extraction

assign op  = opcode_t'(fetch_instr[`OPCODE_MSB:`OPCODE_LSB]);
assign rd  = fetch_instr[`RD_LSB +: `REG_ADDR_WIDTH];
assign rs1 = fetch_instr[`RS1_LSB +: `REG_ADDR_WIDTH];
assign rs2 = fetch_instr[`RS2_LSB +: `REG_ADDR_WIDTH];
assign imm = {{(`DATA_WIDTH-`IMM_WIDTH){fetch_instr[`IMM_WIDTH-1]}},
              fetch_instr[`IMM_WIDTH-1:0]};

// Operand usage per opcode
// Unknown codes behave as NOP
assign uses_rs2  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL, OP_BEQ};
assign uses_rs1  = uses_rs2 || (op == OP_ADDI);
assign writes_rd = uses_rs1 && (op != OP_BEQ);
assign is_mul    = (op == OP_MUL);

//////////////////////////////////////////////////
// Issue control

// Wait until every source has committed
assign src_busy  = (uses_rs1 && pending_q[rs1]) || (uses_rs2 && pending_q[rs2]);
assign can_issue = !src_busy && !rob_full && !take_branch;

assign decode_stall = fetch_valid && !can_issue;
assign alu_issue    = fetch_valid && can_issue && !is_mul;
assign mul_issue    = fetch_valid && can_issue && is_mul;
// BEQ and NOP take no slot
assign rob_alloc    = (alu_issue || mul_issue) && writes_rd;

// Requests built straight from the register file
always_comb begin
    alu_req.op     = op;
    alu_req.src1   = regs_q[rs1];
    alu_req.src2   = regs_q[rs2];
    alu_req.imm    = imm;
    alu_req.dest   = rd;
    alu_req.pc     = fetch_pc;
    alu_req.rob_id = rob_tail;

    mul_req.src1   = regs_q[rs1];
    mul_req.src2   = regs_q[rs2];
    mul_req.dest   = rd;
    mul_req.pc     = fetch_pc;
    mul_req.rob_id = rob_tail;
end

//////////////////////////////////////////////////
// Register file and scoreboard update

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs_q[i]  <= '0;
            owner_q[i] <= '0;
        end
        pending_q <= '0;
    end else begin
        if (commit_valid) begin
            regs_q[commit_dest] <= commit_data;
            // Release only by the youngest writer
            if (owner_q[commit_dest] == commit_tag) begin
                pending_q[commit_dest] <= 1'b0;
            end
        end
        // New writer wins over a same-cycle release
        if (rob_alloc) begin
            pending_q[rd] <= 1'b1;
            owner_q[rd]   <= rob_tail;
        end
    end
end

// One execution unit per instruction
assert property (@(posedge clock) disable iff (!arst_n) !(alu_issue && mul_issue));

endmodule

// File: src/fetch_stage.sv
`include "core_defines.svh"

module fetch_stage (
    input   logic                       clock,
    input   logic                       arst_n,

    // Start address after reset
    input   logic   [`PC_WIDTH-1:0]     boot_addr,

    // Back-pressure from decode
    input   logic                       stall,

    // Redirect from the ALU
    input   logic                       take_branch,
    input   logic   [`PC_WIDTH-1:0]     branch_pc,

    // Instruction memory, combinational read
    input   logic   [`INSTR_WIDTH-1:0]  imem_data,
    output  logic   [`PC_WIDTH-1:0]     imem_addr,

    // Towards decode
    output  logic                       fetch_valid,
    output  logic   [`INSTR_WIDTH-1:0]  fetch_instr,
    output  logic   [`PC_WIDTH-1:0]     fetch_pc
);

logic [`PC_WIDTH-1:0] pc_q;

// Memory sees the pc directly
assign imem_addr = pc_q;

//////////////////////////////////////////////////
// Program counter and valid flag

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        pc_q        <= boot_addr;
        fetch_valid <= 1'b0;
    end else if (take_branch) begin
        // Wrong-path slot dropped for one cycle
        pc_q        <= branch_pc;
        fetch_valid <= 1'b0;
    end else if (!stall) begin
        pc_q        <= pc_q + `PC_WIDTH'(1);
        fetch_valid <= 1'b1;
    end
end

// Instruction register
// Holds its value while decode is stalled
always_ff @(posedge clock) begin
    if (!stall && !take_branch) begin
        fetch_instr <= imem_data;
        fetch_pc    <= pc_q;
    end
end

// Frozen pc and instruction during a stall
assert property (@(posedge clock) disable iff (!arst_n)
    (stall && !take_branch) |=> ($stable(pc_q) && $stable(fetch_instr)));

endmodule

// File: src/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    // Top four bits of every instruction
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_MUL  = 4'h7,
        OP_BEQ  = 4'h8
    } opcode_t;

    // Decode to ALU
    typedef struct packed {
        opcode_t                        op;
        logic [`DATA_WIDTH-1:0]         src1;
        logic [`DATA_WIDTH-1:0]         src2;
        // Already sign-extended
        logic [`DATA_WIDTH-1:0]         imm;
        logic [`REG_ADDR_WIDTH-1:0]     dest;
        logic [`PC_WIDTH-1:0]           pc;
        logic [`ROB_ID_WIDTH-1:0]       rob_id;
    } alu_op_t;

    // Decode to MUL
    // pc rides along for the commit port
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]         src1;
        logic [`DATA_WIDTH-1:0]         src2;
        logic [`REG_ADDR_WIDTH-1:0]     dest;
        logic [`PC_WIDTH-1:0]           pc;
        logic [`ROB_ID_WIDTH-1:0]       rob_id;
    } mul_op_t;

    // Finished result, ALU or MUL into the reorder buffer
    typedef struct packed {
        logic [`ROB_ID_WIDTH-1:0]       rob_id;
        logic [`REG_ADDR_WIDTH-1:0]     dest;
        logic [`DATA_WIDTH-1:0]         data;
        logic [`PC_WIDTH-1:0]           pc;
    } completion_t;

endpackage

// File: include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath widths
`define DATA_WIDTH      32
`define INSTR_WIDTH     32
// Counts instructions, not bytes
`define PC_WIDTH        16

// Register file
`define REG_COUNT       8
`define REG_ADDR_WIDTH  3

// Reorder buffer, entry count a power of two
`define ROB_ENTRIES     4
`define ROB_ID_WIDTH    2

// Cycles from MUL issue to MUL result
`define MUL_LATENCY     3

// Instruction fields
// Register fields take 3 bits each, MSBs at 27, 23 and 19
`define OPCODE_MSB      31
`define OPCODE_LSB      28
`define RD_LSB          25
`define RS1_LSB         21
`define RS2_LSB         17
// Low bits, sign-extended in decode
`define IMM_WIDTH       16

`endif
